// File: common/l2_axi_settings.svh
// Line and memory depth must be powers of two, and the protected base must lie below the depth
`ifndef L2_AXI_SETTINGS_SVH
`define L2_AXI_SETTINGS_SVH

// Width of a byte address
`define L2_ADDR_BITS 32

// One cache line moves as a single AXI beat
`define L2_LINE_BITS 128

// Bytes per line, also the strobe width
`define L2_LINE_BYTES (`L2_LINE_BITS / 8)

// Number of lines held by the backing memory
`define L2_MEM_LINES 64

// Lines from this index up need a privileged access
`define L2_PROT_BASE_LINE 48

`endif

// File: common/l2_axi_pkg.sv
// Single-beat AXI subset only: no burst, size, cache, QoS, region, ID or user fields
`default_nettype none

`include "l2_axi_settings.svh"

package l2_axi_pkg;

    typedef logic [`L2_LINE_BITS-1:0] line_t;
    typedef logic [`L2_LINE_BYTES-1:0] strb_t;
    typedef logic [`L2_ADDR_BITS-1:0] addr_t;

    // Address payload shared by AR and AW
    typedef struct packed {
        addr_t      addr;
        // Bit 0 set marks a privileged access
        logic [2:0] prot;
    } axi_addr_t;

    // Everything the master drives
    typedef struct packed {
        logic      aw_valid;
        axi_addr_t aw;
        logic      w_valid;
        line_t     w_data;
        strb_t     w_strb;
        logic      b_ready;
        logic      ar_valid;
        axi_addr_t ar;
        logic      r_ready;
    } axi_mst_out_t;

    // Everything the slave drives back
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        logic [1:0] b_resp;
        logic       ar_ready;
        logic       r_valid;
        line_t      r_data;
        logic [1:0] r_resp;
    } axi_mst_in_t;

    // Bit 1 of a response code flags an error
    localparam logic [1:0] AXI_OKAY   = 2'b00;
    localparam logic [1:0] AXI_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: l2_amba/l2_amba_bridge.sv
// One line request in flight at a time; the requester must accept every completion pulse
`timescale 1ns/1ps
`default_nettype none

module l2_amba_bridge
    import l2_axi_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_nrst,
    output logic              o_req_ready,
    input  wire               i_req_valid,
    input  wire               i_req_write,
    input  wire  [2:0]        i_req_prot,
    input  wire  addr_t       i_req_addr,
    input  wire  strb_t       i_req_strob,
    input  wire  line_t       i_req_data,
    output line_t             o_resp_data,
    output logic              o_resp_valid,
    output logic              o_resp_ack,
    output logic              o_resp_load_fault,
    output logic              o_resp_store_fault,
    input  wire  axi_mst_in_t i_msti,
    output axi_mst_out_t      o_msto
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READING,
        ST_WRITING,
        ST_WACK
    } state_e;

    state_e state_q;
    state_e state_d;

    // Write payload captured with AW since the requester may move on after acceptance
    line_t w_data_q;
    strb_t w_strb_q;
    logic  aw_take;

    always_comb begin
        axi_mst_out_t msto;
        logic         next_ready;

        msto = '0;
        next_ready = 1'b0;
        aw_take = 1'b0;
        state_d = state_q;

        o_req_ready = 1'b0;
        o_resp_valid = 1'b0;
        o_resp_ack = 1'b0;
        o_resp_load_fault = 1'b0;
        o_resp_store_fault = 1'b0;

        case (state_q)
            ST_IDLE: begin
                next_ready = 1'b1;
            end
            ST_READING: begin
                msto.r_ready = 1'b1;
                if (i_msti.r_valid) begin
                    o_resp_valid = 1'b1;
                    o_resp_ack = 1'b1;
                    o_resp_load_fault = i_msti.r_resp[1];
                    next_ready = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            ST_WRITING: begin
                // Single beat carries the whole line
                msto.w_valid = 1'b1;
                if (i_msti.w_ready) begin
                    state_d = ST_WACK;
                end
            end
            ST_WACK: begin
                msto.b_ready = 1'b1;
                if (i_msti.b_valid) begin
                    o_resp_valid = 1'b1;
                    o_resp_ack = 1'b1;
                    o_resp_store_fault = i_msti.b_resp[1];
                    next_ready = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase

        // A pending request may start in the same cycle as the previous completion
        if (next_ready && i_req_valid) begin
            if (!i_req_write) begin
                msto.ar_valid = 1'b1;
                if (i_msti.ar_ready) begin
                    o_req_ready = 1'b1;
                    state_d = ST_READING;
                end
            end else begin
                msto.aw_valid = 1'b1;
                if (i_msti.aw_ready) begin
                    o_req_ready = 1'b1;
                    aw_take = 1'b1;
                    state_d = ST_WRITING;
                end
            end
        end

        // Address fields only matter in the acceptance cycle
        msto.ar.addr = i_req_addr;
        msto.ar.prot = i_req_prot;
        msto.aw.addr = i_req_addr;
        msto.aw.prot = i_req_prot;
        msto.w_data = w_data_q;
        msto.w_strb = w_strb_q;

        o_msto = msto;
    end

    // Read data passes straight through and is only meaningful with the ack
    assign o_resp_data = i_msti.r_data;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (aw_take) begin
            w_data_q <= i_req_data;
            w_strb_q <= i_req_strob;
        end
    end

endmodule

`default_nettype wire

// File: logic/axi_line_mem.sv
// Single-beat slave, one transaction at a time; AR wins when AR and AW arrive together
`timescale 1ns/1ps
`default_nettype none

`include "l2_axi_settings.svh"

module axi_line_mem
    import l2_axi_pkg::*;
(
    input  wire                i_clk,
    input  wire                i_nrst,
    input  wire  axi_mst_out_t i_msto,
    output axi_mst_in_t        o_msti
);

    localparam int unsigned LINE_OFFS = $clog2(`L2_LINE_BYTES);
    localparam int unsigned IDX_BITS = $clog2(`L2_MEM_LINES);

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_RDATA,
        MS_WDATA,
        MS_BRESP
    } mstate_e;

    mstate_e   state_q;
    mstate_e   state_d;
    axi_addr_t req_q;
    line_t     mem_q [`L2_MEM_LINES];

    logic                free;
    logic                ar_take;
    logic                aw_take;
    logic                w_take;
    logic                req_fault;
    logic [IDX_BITS-1:0] req_idx;
    logic [1:0]          resp;

    // Out of range, or an unprivileged touch of the protected top lines
    function automatic logic access_fault(input axi_addr_t a);
        logic [`L2_ADDR_BITS-LINE_OFFS-1:0] line;
        line = a.addr[`L2_ADDR_BITS-1:LINE_OFFS];
        return (line >= `L2_MEM_LINES) || ((line >= `L2_PROT_BASE_LINE) && !a.prot[0]);
    endfunction

    // Also free while the current response is being taken, so requests can run back to back
    assign free = (state_q == MS_IDLE)
               || ((state_q == MS_RDATA) && i_msto.r_ready)
               || ((state_q == MS_BRESP) && i_msto.b_ready);

    assign ar_take = free && i_msto.ar_valid;
    assign aw_take = free && !i_msto.ar_valid && i_msto.aw_valid;
    assign w_take = (state_q == MS_WDATA) && i_msto.w_valid;

    assign req_idx = req_q.addr[LINE_OFFS +: IDX_BITS];
    assign req_fault = access_fault(req_q);
    assign resp = req_fault ? AXI_SLVERR : AXI_OKAY;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_RDATA: begin
                if (i_msto.r_ready) begin
                    state_d = MS_IDLE;
                end
            end
            MS_WDATA: begin
                if (w_take) begin
                    state_d = MS_BRESP;
                end
            end
            MS_BRESP: begin
                if (i_msto.b_ready) begin
                    state_d = MS_IDLE;
                end
            end
            default: begin
            end
        endcase

        if (ar_take) begin
            state_d = MS_RDATA;
        end else if (aw_take) begin
            state_d = MS_WDATA;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= MS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address payload is held through the data and response phases
    always_ff @(posedge i_clk) begin
        if (ar_take) begin
            req_q <= i_msto.ar;
        end else if (aw_take) begin
            req_q <= i_msto.aw;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < `L2_MEM_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (w_take && !req_fault) begin
            for (int b = 0; b < `L2_LINE_BYTES; b++) begin
                if (i_msto.w_strb[b]) begin
                    mem_q[req_idx][8*b +: 8] <= i_msto.w_data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        o_msti.ar_ready = free;
        o_msti.aw_ready = free && !i_msto.ar_valid;
        o_msti.w_ready = (state_q == MS_WDATA);
        o_msti.b_valid = (state_q == MS_BRESP);
        o_msti.b_resp = resp;
        o_msti.r_valid = (state_q == MS_RDATA);
        // Faulting reads return zero
        o_msti.r_data = req_fault ? '0 : mem_q[req_idx];
        o_msti.r_resp = resp;
    end

endmodule

`default_nettype wire

// File: logic/l2_axi_top.sv
// Read completes one cycle after acceptance, write two; completions cannot be stalled
`timescale 1ns/1ps
`default_nettype none

module l2_axi_top
    import l2_axi_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_nrst,
    output logic        o_req_ready,
    input  wire         i_req_valid,
    input  wire         i_req_write,
    input  wire  [2:0]  i_req_prot,
    input  wire  addr_t i_req_addr,
    input  wire  strb_t i_req_strob,
    input  wire  line_t i_req_data,
    output line_t       o_resp_data,
    output logic        o_resp_valid,
    output logic        o_resp_ack,
    output logic        o_resp_load_fault,
    output logic        o_resp_store_fault
);

    axi_mst_out_t msto;
    axi_mst_in_t  msti;

    l2_amba_bridge u_bridge (
        .i_clk              (i_clk),
        .i_nrst             (i_nrst),
        .o_req_ready        (o_req_ready),
        .i_req_valid        (i_req_valid),
        .i_req_write        (i_req_write),
        .i_req_prot         (i_req_prot),
        .i_req_addr         (i_req_addr),
        .i_req_strob        (i_req_strob),
        .i_req_data         (i_req_data),
        .o_resp_data        (o_resp_data),
        .o_resp_valid       (o_resp_valid),
        .o_resp_ack         (o_resp_ack),
        .o_resp_load_fault  (o_resp_load_fault),
        .o_resp_store_fault (o_resp_store_fault),
        .i_msti             (msti),
        .o_msto             (msto)
    );

    axi_line_mem u_mem (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_msto (msto),
        .o_msti (msti)
    );

endmodule

`default_nettype wire

// File: verif/tb_l2_axi.sv
// Drives only the cache side and expects fixed latencies of 1 cycle for reads and 2 for writes
`timescale 1ns/1ps
`default_nettype none

`include "l2_axi_settings.svh"

module tb_l2_axi
    import l2_axi_pkg::*;
();

    localparam int TIMEOUT = 20;

    // The one transaction the checker expects to complete next
    typedef struct packed {
        logic        valid;
        logic        write;
        line_t       data;
        logic        load_fault;
        logic        store_fault;
        logic [31:0] cycle;
    } expect_t;

    logic       i_clk;
    logic       i_nrst;
    logic       o_req_ready;
    logic       i_req_valid;
    logic       i_req_write;
    logic [2:0] i_req_prot;
    addr_t      i_req_addr;
    strb_t      i_req_strob;
    line_t      i_req_data;
    line_t      o_resp_data;
    logic       o_resp_valid;
    logic       o_resp_ack;
    logic       o_resp_load_fault;
    logic       o_resp_store_fault;

    line_t       model_mem [`L2_MEM_LINES];
    expect_t     pend;
    logic [31:0] rng_state = 32'd79936;
    logic [31:0] cycle_cnt = '0;
    int          mismatches = 0;
    int          other_errors = 0;

    l2_axi_top u_l2_axi_top (
        .i_clk              (i_clk),
        .i_nrst             (i_nrst),
        .o_req_ready        (o_req_ready),
        .i_req_valid        (i_req_valid),
        .i_req_write        (i_req_write),
        .i_req_prot         (i_req_prot),
        .i_req_addr         (i_req_addr),
        .i_req_strob        (i_req_strob),
        .i_req_data         (i_req_data),
        .o_resp_data        (o_resp_data),
        .o_resp_valid       (o_resp_valid),
        .o_resp_ack         (o_resp_ack),
        .o_resp_load_fault  (o_resp_load_fault),
        .o_resp_store_fault (o_resp_store_fault)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < `L2_LINE_BITS / 32; i++) begin
            l[32*i +: 32] = next_random();
        end
        return l;
    endfunction

    // Any byte inside the given line
    function automatic addr_t line_addr(input int unsigned line);
        return addr_t'(line * `L2_LINE_BYTES + next_random() % `L2_LINE_BYTES);
    endfunction

    function automatic logic is_fault(input addr_t addr, input logic [2:0] prot);
        longint unsigned idx;
        idx = addr / `L2_LINE_BYTES;
        return (idx >= `L2_MEM_LINES) || ((idx >= `L2_PROT_BASE_LINE) && !prot[0]);
    endfunction

    task automatic check_value(input logic [`L2_LINE_BITS-1:0] actual,
                               input logic [`L2_LINE_BITS-1:0] expected, input string what);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_quiet();
        check_value(o_req_ready, 1'b0, "req_ready while idle");
        check_value(o_resp_valid, 1'b0, "resp_valid while idle");
        check_value(o_resp_ack, 1'b0, "resp_ack while idle");
        check_value(o_resp_load_fault, 1'b0, "load fault while idle");
        check_value(o_resp_store_fault, 1'b0, "store fault while idle");
    endtask

    // Called once per cycle at the falling edge
    task automatic observe_completion();
        logic due;
        due = pend.valid && (cycle_cnt - pend.cycle == (pend.write ? 2 : 1));
        check_value(o_resp_valid, due, "resp_valid");
        check_value(o_resp_ack, due, "resp_ack");
        if (o_resp_ack) begin
            if (!pend.valid) begin
                other_errors++;
                $display("Completion at %0t with no request outstanding", $time);
            end else begin
                check_value(cycle_cnt - pend.cycle, pend.write ? 2 : 1, "completion latency");
                check_value(o_resp_load_fault, pend.load_fault, "load fault");
                check_value(o_resp_store_fault, pend.store_fault, "store fault");
                if (!pend.write) begin
                    check_value(o_resp_data, pend.data, "read data");
                end
                pend.valid = 1'b0;
            end
        end else if (pend.valid && (cycle_cnt - pend.cycle > TIMEOUT)) begin
            other_errors++;
            $display("Timeout at %0t: no completion within %0d cycles", $time, TIMEOUT);
            pend.valid = 1'b0;
        end
    endtask

    task automatic send_request(input logic write, input logic [2:0] prot, input addr_t addr,
                                input strb_t strb, input line_t data);
        int          waited;
        logic        fault;
        int unsigned idx;
        waited = 0;
        fault = is_fault(addr, prot);
        idx = (addr / `L2_LINE_BYTES) % `L2_MEM_LINES;
        @(posedge i_clk);
        i_req_valid <= 1'b1;
        i_req_write <= write;
        i_req_prot <= prot;
        i_req_addr <= addr;
        i_req_strob <= strb;
        i_req_data <= data;
        while (waited < TIMEOUT) begin
            @(negedge i_clk);
            observe_completion();
            if (o_req_ready) begin
                break;
            end
            waited++;
        end
        if (waited == TIMEOUT) begin
            other_errors++;
            $display("Timeout at %0t: request not accepted within %0d cycles", $time, TIMEOUT);
        end else begin
            if (pend.valid) begin
                other_errors++;
                $display("Request accepted at %0t while the previous one was open", $time);
            end
            pend.valid = 1'b1;
            pend.write = write;
            pend.cycle = cycle_cnt;
            pend.load_fault = !write && fault;
            pend.store_fault = write && fault;
            pend.data = (write || fault) ? '0 : model_mem[idx];
            if (write && !fault) begin
                for (int b = 0; b < `L2_LINE_BYTES; b++) begin
                    if (strb[b]) begin
                        model_mem[idx][8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
        end
    endtask

    // Drop the request and let the last transaction finish
    task automatic finish_requests();
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_req_valid <= 1'b0;
        while (pend.valid && waited < TIMEOUT) begin
            @(negedge i_clk);
            observe_completion();
            waited++;
        end
        if (pend.valid) begin
            other_errors++;
            $display("Timeout at %0t: last request never completed", $time);
            pend.valid = 1'b0;
        end
    endtask

    initial begin
        int unsigned lines [3];
        int unsigned line;
        logic [2:0]  prot;
        addr_t       addr;
        line_t       data;

        i_nrst = 1'b0;
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        i_req_prot = '0;
        i_req_addr = '0;
        i_req_strob = '0;
        i_req_data = '0;
        pend = '0;
        for (int i = 0; i < `L2_MEM_LINES; i++) begin
            model_mem[i] = '0;
        end

        for (int i = 0; i < 10; i++) begin
            @(negedge i_clk);
            check_quiet();
        end
        @(posedge i_clk);
        i_nrst <= 1'b1;
        @(negedge i_clk);
        check_quiet();

        // Full line write and read back, isolated so latency is clear
        for (int n = 0; n < 4; n++) begin
            addr = line_addr(next_random() % `L2_MEM_LINES);
            prot = 3'(next_random()) | 3'b001;
            send_request(1'b1, prot, addr, '1, random_line());
            finish_requests();
            send_request(1'b0, prot, addr, '0, '0);
            finish_requests();
        end

        // Partial strobes hammering a few lines
        for (int i = 0; i < 3; i++) begin
            lines[i] = next_random() % `L2_MEM_LINES;
        end
        for (int n = 0; n < 30; n++) begin
            send_request(1'b1, 3'b001, line_addr(lines[n % 3]), strb_t'(next_random()),
                         random_line());
        end
        for (int i = 0; i < 3; i++) begin
            send_request(1'b0, 3'b001, line_addr(lines[i]), '0, '0);
        end
        finish_requests();

        // Beyond the memory, then the line it would alias onto
        for (int n = 0; n < 6; n++) begin
            line = `L2_MEM_LINES + next_random() % 1024;
            send_request(1'b1, 3'b111, line_addr(line), '1, random_line());
            send_request(1'b0, 3'b111, line_addr(line), '0, '0);
            send_request(1'b0, 3'b001, line_addr(line % `L2_MEM_LINES), '0, '0);
        end
        send_request(1'b0, 3'b001, addr_t'('1), '0, '0);
        finish_requests();

        // Protected region with and without privilege
        for (int n = 0; n < 6; n++) begin
            line = `L2_PROT_BASE_LINE + next_random() % (`L2_MEM_LINES - `L2_PROT_BASE_LINE);
            prot = 3'(next_random()) & 3'b110;
            send_request(1'b0, prot, line_addr(line), '0, '0);
            send_request(1'b1, prot, line_addr(line), '1, random_line());
            send_request(1'b0, 3'b001, line_addr(line), '0, '0);
            send_request(1'b1, 3'b011, line_addr(line), strb_t'(next_random()), random_line());
            send_request(1'b0, 3'b101, line_addr(line), '0, '0);
        end
        finish_requests();

        // Back to back random traffic
        for (int n = 0; n < 400; n++) begin
            if (next_random() % 8 == 0) begin
                addr = next_random();
            end else begin
                addr = line_addr(next_random() % (`L2_MEM_LINES + 8));
            end
            prot = 3'(next_random());
            data = random_line();
            send_request(next_random() % 2 == 1, prot, addr, strb_t'(next_random()), data);
        end
        finish_requests();

        $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/l2_axi_pkg.sv
l2_amba/l2_amba_bridge.sv
logic/axi_line_mem.sv
logic/l2_axi_top.sv
verif/tb_l2_axi.sv

// File: Bender.yml
package:
  name: l2_axi

sources:
  - include_dirs:
      - common
    files:
      - common/l2_axi_pkg.sv
      - l2_amba/l2_amba_bridge.sv
      - logic/axi_line_mem.sv
      - logic/l2_axi_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_l2_axi.sv
